// File: logic/xdcr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Transducer drive package.
// Sizes, bus select codes, control register map
// and the per-channel value array type.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xdcr_pkg;

    localparam int N_XDCR    = 4;  // Transducer channels.
    localparam int VAL_W     = 8;
    localparam int MOD_DEPTH = 16; // Modulation table entries.
    localparam int MOD_IDX_W = 4;

    localparam logic [VAL_W-1:0] CYCLE_MIN = 8'd2;
    localparam logic [VAL_W-1:0] CYCLE_RST = 8'hFF;

    localparam logic [1:0] SEL_CTL = 2'd0;
    localparam logic [1:0] SEL_DP  = 2'd1;
    localparam logic [1:0] SEL_MOD = 2'd2;

    localparam logic [3:0] ADDR_CYCLE   = 4'd0;
    localparam logic [3:0] ADDR_MOD_DIV = 4'd1;
    localparam logic [3:0] ADDR_MOD_LEN = 4'd2;
    localparam logic [3:0] ADDR_STEP    = 4'd3;
    localparam logic [3:0] ADDR_MODE    = 4'd4; // Bit 0 modulator, bit 1 silencer.

    typedef logic [VAL_W-1:0] val_arr_t [N_XDCR];

endpackage

`default_nettype wire

// File: logic/cpu_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host write bus.
// Single-cycle strobed writes, no handshake.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface cpu_bus_if;

    logic        en;
    logic        we;
    logic [1:0]  sel;   // Bank select.
    logic [3:0]  addr;
    logic [15:0] wdata;

    modport ctl_port (input en, we, sel, addr, wdata);

    modport dp_port (input en, we, sel, addr, wdata);

    modport mod_port (input en, we, sel, addr, wdata);

endinterface

`default_nettype wire

// File: logic/ctl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Control register bank.
// Drive period, modulation divider and length,
// silencer step and the two mode enables.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ctl_regs (
    input  logic                          clk_l,
    input  logic                          rst_n,
    cpu_bus_if.ctl_port                   bus,
    output logic [xdcr_pkg::VAL_W-1:0]    cycle,
    output logic [xdcr_pkg::VAL_W-1:0]    mod_div,
    output logic [xdcr_pkg::MOD_IDX_W:0]  mod_len,
    output logic [xdcr_pkg::VAL_W-1:0]    step,
    output logic                          mod_en,
    output logic                          sil_en
);
    import xdcr_pkg::*;

    logic                wr;
    logic [VAL_W-1:0]    wval;
    logic [MOD_IDX_W:0]  len_val;

    assign wr   = bus.en && bus.we && (bus.sel == SEL_CTL);
    assign wval = bus.wdata[VAL_W-1:0];

    // Table length kept within 1 to MOD_DEPTH.
    always_comb begin
        len_val = bus.wdata[MOD_IDX_W:0];
        if (len_val == '0)
            len_val = (MOD_IDX_W+1)'(1);
        else if (len_val > MOD_DEPTH)
            len_val = (MOD_IDX_W+1)'(MOD_DEPTH);
    end

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            cycle   <= CYCLE_RST;
            mod_div <= '0;
            mod_len <= (MOD_IDX_W+1)'(1);
            step    <= '0;
            mod_en  <= 1'b0;
            sil_en  <= 1'b0;
        end else if (wr) begin
            case (bus.addr)
                ADDR_CYCLE:   cycle   <= (wval < CYCLE_MIN) ? CYCLE_MIN : wval;
                ADDR_MOD_DIV: mod_div <= wval;
                ADDR_MOD_LEN: mod_len <= len_val;
                ADDR_STEP:    step    <= wval;
                ADDR_MODE: begin
                    mod_en <= bus.wdata[0];
                    sil_en <= bus.wdata[1];
                end
                default: ;                      // Unmapped, dropped.
            endcase
        end
    end

    // The PWM counter needs at least two states per period.
    a_cycle_min: assert property (
        @(posedge clk_l) disable iff (!rst_n)
        cycle >= CYCLE_MIN
    ) else $error("cycle register fell below %0d", CYCLE_MIN);

endmodule

`default_nettype wire

// File: logic/duty_phase_ram.sv
// ~~~~~~~~~~~~~~~~~~~~
// Duty and phase store.
// One duty and one phase per transducer,
// loaded by host writes to the DP bank.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module duty_phase_ram (
    input  logic               clk_l,
    input  logic               rst_n,
    cpu_bus_if.dp_port         bus,
    output xdcr_pkg::val_arr_t duty,
    output xdcr_pkg::val_arr_t phase
);
    import xdcr_pkg::*;

    logic wr;
    logic in_range;

    assign wr       = bus.en && bus.we && (bus.sel == SEL_DP);
    assign in_range = (bus.addr < N_XDCR);

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            duty  <= '{default: '0};
            phase <= '{default: '0};
        end else if (wr && in_range) begin
            for (int i = 0; i < N_XDCR; i++) begin
                if (bus.addr == i) begin
                    duty[i]  <= bus.wdata[VAL_W-1:0];      // Low byte.
                    phase[i] <= bus.wdata[2*VAL_W-1:VAL_W]; // High byte.
                end
            end
        end
    end

    // Writes past the last channel are ignored by the store.
    a_addr_range: assert property (
        @(posedge clk_l) disable iff (!rst_n)
        wr |-> in_range
    ) else $warning("duty/phase write to unused address %0h ignored", bus.addr);

endmodule

`default_nettype wire

// File: logic/modulator.sv
// ~~~~~~~~~~~~~~~~~~~~
// Amplitude modulator.
// Sample table with a period-based index, scales
// every duty by the current sample. Phase passes.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module modulator (
    input  logic                          clk_l,
    input  logic                          rst_n,
    cpu_bus_if.mod_port                   bus,
    input  logic                          period_start,
    input  logic                          mod_en,
    input  logic [xdcr_pkg::VAL_W-1:0]    mod_div,
    input  logic [xdcr_pkg::MOD_IDX_W:0]  mod_len,
    input  xdcr_pkg::val_arr_t            duty_in,
    input  xdcr_pkg::val_arr_t            phase_in,
    output xdcr_pkg::val_arr_t            duty_out,
    output xdcr_pkg::val_arr_t            phase_out
);
    import xdcr_pkg::*;

    logic [VAL_W-1:0]      mod_mem [MOD_DEPTH];
    logic [MOD_IDX_W-1:0]  idx;
    logic [VAL_W-1:0]      div_cnt;
    logic [VAL_W-1:0]      div_lim;
    logic [VAL_W-1:0]      sample;
    logic                  div_last;
    logic                  idx_last;
    val_arr_t              duty_scaled;

    assign div_lim  = (mod_div == '0) ? VAL_W'(1) : mod_div; // Zero acts as one.
    assign div_last = (div_cnt >= div_lim - 1'b1);
    assign idx_last = ({1'b0, idx} + 1'b1 >= mod_len);
    assign sample   = mod_mem[idx];

    always_ff @(posedge clk_l) begin
        if (bus.en && bus.we && (bus.sel == SEL_MOD))
            mod_mem[bus.addr[MOD_IDX_W-1:0]] <= bus.wdata[VAL_W-1:0];
    end

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            idx     <= '0;
        end else if (!mod_en) begin
            div_cnt <= '0;
            idx     <= '0;
        end else if ({1'b0, idx} >= mod_len) begin
            idx <= '0;                              // Length shrunk under us.
        end else if (period_start) begin
            if (div_last) begin
                div_cnt <= '0;
                idx     <= idx_last ? '0 : idx + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < N_XDCR; i++) begin : g_scale
        logic [2*VAL_W-1:0] prod;
        assign prod           = duty_in[i] * sample;
        assign duty_scaled[i] = prod[2*VAL_W-1:VAL_W]; // Product >> 8.
    end

    always_ff @(posedge clk_l) begin
        duty_out  <= mod_en ? duty_scaled : duty_in;
        phase_out <= phase_in;
    end

    a_idx_range: assert property (
        @(posedge clk_l) disable iff (!rst_n)
        $stable(mod_len) |-> ({1'b0, idx} < mod_len)
    ) else $error("modulation index %0d not below length %0d", idx, mod_len);

endmodule

`default_nettype wire

// File: logic/silencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Silencer.
// Slews each duty and phase toward its target,
// at most one step per drive period.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module silencer (
    input  logic                        clk_l,
    input  logic                        rst_n,
    input  logic                        period_start,
    input  logic                        sil_en,
    input  logic [xdcr_pkg::VAL_W-1:0]  step,
    input  xdcr_pkg::val_arr_t          duty_in,
    input  xdcr_pkg::val_arr_t          phase_in,
    output xdcr_pkg::val_arr_t          duty_out,
    output xdcr_pkg::val_arr_t          phase_out
);
    import xdcr_pkg::*;

    logic bypass;

    // One step toward the target, landing on it once close enough.
    function automatic logic [VAL_W-1:0] slew(
        input logic [VAL_W-1:0] cur,
        input logic [VAL_W-1:0] tgt,
        input logic [VAL_W-1:0] lim
    );
        logic             up;
        logic [VAL_W-1:0] gap;
        up  = (tgt > cur);
        gap = up ? tgt - cur : cur - tgt;
        if (gap <= lim)
            return tgt;
        return up ? cur + lim : cur - lim;
    endfunction

    assign bypass = !sil_en || (step == '0);

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            duty_out  <= '{default: '0};
            phase_out <= '{default: '0};
        end else if (period_start) begin
            for (int i = 0; i < N_XDCR; i++) begin
                if (bypass) begin
                    duty_out[i]  <= duty_in[i];
                    phase_out[i] <= phase_in[i];
                end else begin
                    duty_out[i]  <= slew(duty_out[i], duty_in[i], step);
                    phase_out[i] <= slew(phase_out[i], phase_in[i], step); // Linear, no wrap.
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pwm_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// PWM generator.
// Shared period counter with a start pulse, and
// one phase-shifted pulse per transducer.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pwm_gen (
    input  logic                          clk_l,
    input  logic                          rst_n,
    input  logic [xdcr_pkg::VAL_W-1:0]    cycle,
    input  xdcr_pkg::val_arr_t            duty,
    input  xdcr_pkg::val_arr_t            phase,
    output logic [xdcr_pkg::N_XDCR-1:0]   pwm_out,
    output logic                          period_start
);
    import xdcr_pkg::*;

    logic [VAL_W-1:0] cnt;
    logic [VAL_W-1:0] cycle_l;   // Period length in use.
    logic             wrap;
    val_arr_t         duty_l;
    val_arr_t         phase_l;

    assign wrap = (cnt >= cycle_l - 1'b1);

    // Everything for the next period is taken on the wrap edge.
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            cycle_l      <= CYCLE_RST;
            period_start <= 1'b0;
            duty_l       <= '{default: '0};
            phase_l      <= '{default: '0};
        end else if (wrap) begin
            cnt          <= '0;
            cycle_l      <= cycle;
            period_start <= 1'b1;
            duty_l       <= duty;
            phase_l      <= phase;
        end else begin
            cnt          <= cnt + 1'b1;
            period_start <= 1'b0;
        end
    end

    for (genvar i = 0; i < N_XDCR; i++) begin : g_ch
        logic [VAL_W:0] diff;
        logic [VAL_W:0] rel;
        assign diff       = {1'b0, cnt} - {1'b0, phase_l[i]};
        assign rel        = diff[VAL_W] ? diff + {1'b0, cycle_l} : diff; // Modulo the period.
        assign pwm_out[i] = !rel[VAL_W] && (rel[VAL_W-1:0] < duty_l[i]);
    end

    a_cnt_range: assert property (
        @(posedge clk_l) disable iff (!rst_n)
        cnt < cycle_l
    ) else $error("period counter %0d not below cycle %0d", cnt, cycle_l);

endmodule

`default_nettype wire

// File: logic/xdcr_drive_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Phased-array drive top level.
// Host bus into the register banks, then
// store, modulator, silencer and PWM in a chain.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xdcr_drive_top (
    input  logic                         clk_l,
    input  logic                         rst_n,
    input  logic                         bus_en,
    input  logic                         bus_we,
    input  logic [1:0]                   bus_sel,
    input  logic [3:0]                   bus_addr,
    input  logic [15:0]                  bus_wdata,
    output logic [xdcr_pkg::N_XDCR-1:0]  pwm_out,
    output logic                         period_start
);
    import xdcr_pkg::*;

    logic [VAL_W-1:0]    cycle;
    logic [VAL_W-1:0]    mod_div;
    logic [MOD_IDX_W:0]  mod_len;
    logic [VAL_W-1:0]    step;
    logic                mod_en;
    logic                sil_en;
    val_arr_t            duty_n, phase_n;   // Stored.
    val_arr_t            duty_m, phase_m;   // Modulated.
    val_arr_t            duty_s, phase_s;   // Slewed.

    cpu_bus_if bus_i ();

    assign bus_i.en    = bus_en;
    assign bus_i.we    = bus_we;
    assign bus_i.sel   = bus_sel;
    assign bus_i.addr  = bus_addr;
    assign bus_i.wdata = bus_wdata;

    ctl_regs ctl_regs_i (
        .clk_l, .rst_n, .bus(bus_i.ctl_port),
        .cycle, .mod_div, .mod_len, .step, .mod_en, .sil_en
    );

    duty_phase_ram duty_phase_ram_i (
        .clk_l, .rst_n, .bus(bus_i.dp_port), .duty(duty_n), .phase(phase_n)
    );

    modulator modulator_i (
        .clk_l, .rst_n, .bus(bus_i.mod_port), .period_start, .mod_en, .mod_div, .mod_len,
        .duty_in(duty_n), .phase_in(phase_n), .duty_out(duty_m), .phase_out(phase_m)
    );

    silencer silencer_i (
        .clk_l, .rst_n, .period_start, .sil_en, .step,
        .duty_in(duty_m), .phase_in(phase_m), .duty_out(duty_s), .phase_out(phase_s)
    );

    pwm_gen pwm_gen_i (
        .clk_l, .rst_n, .cycle, .duty(duty_s), .phase(phase_s), .pwm_out, .period_start
    );

endmodule

`default_nettype wire

// File: test/xdcr_drive_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Drive checker.
// Measures each PWM period between period starts
// and compares high counts, first high position
// and period length with the expected values.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xdcr_drive_checker (
    input  logic                  clk_l,
    input  logic                  rst_n,
    input  logic [3:0]            pwm_out,
    input  logic                  period_start,
    input  logic                  req,
    input  int                    test_id,
    input  logic [7:0]            exp_cycle,
    input  int                    n_per,
    input  logic                  align,
    input  logic [5:0][3:0][7:0]  exp_duty,
    input  logic [3:0][7:0]       exp_phase,
    output int                    done_cnt,
    output int                    err_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TMO = 600;  // Clocks, longer than any period.

    int         hi_cnt [4];
    logic [7:0] first_hi [4];
    int         per_len;
    bit         tmo;

    // First high clock of a period from the phase rule, ff when never high.
    function automatic logic [7:0] first_pos(input int p, input int d, input int c);
        if (d == 0)
            return 8'hff;
        if (p + d > c)
            return 8'h00;
        return 8'(p);
    endfunction

    task automatic report_mismatch(input int p, input string what, input int got,
                                   input int exp);
        $display("CHECK FAILED test %0d period %0d: %s got %h exp %h",
                 test_id, p, what, got, exp);
    endtask

    task automatic sample_at(input int k);
        for (int i = 0; i < 4; i++) begin
            if (pwm_out[i]) begin
                hi_cnt[i]++;
                if (first_hi[i] == 8'hff)
                    first_hi[i] = 8'(k);
            end
        end
    endtask

    task automatic wait_start();
        int k;
        k = 0;
        while (!period_start && k < TMO) begin
            @(posedge clk_l);
            k++;
        end
        tmo = !period_start;
    endtask

    // Current sample is position 0 of the period.
    task automatic measure_period();
        int k;
        for (int i = 0; i < 4; i++) begin
            hi_cnt[i]   = 0;
            first_hi[i] = 8'hff;
        end
        k = 0;
        sample_at(k);
        k++;
        @(posedge clk_l);
        while (!period_start && k < TMO) begin
            sample_at(k);
            k++;
            @(posedge clk_l);
        end
        tmo     = !period_start;
        per_len = k;
    endtask

    task automatic run_check();
        int         fails;
        bit         have;
        logic [7:0] exp_first;
        fails = 0;
        have  = 0;
        wait_start();
        // An aligned test searches from the first full period instead.
        for (int s = 0; s < 2 && !tmo && !align; s++)
            measure_period();
        if (align && !tmo) begin
            for (int t = 0; t < 20 && !tmo && !have; t++) begin
                measure_period();
                have = (hi_cnt[0] == int'(exp_duty[0][0]));
            end
            if (!have && !tmo) begin
                $display("test %0d: expected duty sequence never started", test_id);
                fails++;
            end
        end
        for (int p = 0; p < n_per && !tmo; p++) begin
            if (!(p == 0 && have))
                measure_period();
            if (!tmo) begin
                if (per_len != int'(exp_cycle)) begin
                    report_mismatch(p, "period_start spacing", per_len, exp_cycle);
                    fails++;
                end
                for (int i = 0; i < 4; i++) begin
                    exp_first = first_pos(exp_phase[i], exp_duty[p][i], exp_cycle);
                    if (hi_cnt[i] != int'(exp_duty[p][i])) begin
                        report_mismatch(p, $sformatf("pwm_out[%0d] high count", i),
                                        hi_cnt[i], exp_duty[p][i]);
                        fails++;
                    end
                    if (first_hi[i] != exp_first) begin
                        report_mismatch(p, $sformatf("pwm_out[%0d] first high", i),
                                        first_hi[i], exp_first);
                        fails++;
                    end
                end
            end
        end
        if (tmo) begin
            $display("test %0d: no period_start seen within %0d clocks", test_id, TMO);
            fails++;
        end
        if (fails == 0)
            $display("test %0d: ok, %0d periods", test_id, n_per);
        else
            $display("test %0d: %0d mismatches", test_id, fails);
        err_cnt += fails;
        done_cnt++;
    endtask

    initial begin
        done_cnt = 0;
        err_cnt  = 0;
        forever begin
            @(posedge clk_l);
            if (rst_n && req)
                run_check();
        end
    end

endmodule

`default_nettype wire

// File: test/xdcr_drive_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Drive testbench.
// Applies a table of register writes and
// expected PWM results, one row per test.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xdcr_drive_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import xdcr_pkg::*;

    localparam int NROW = 7;
    localparam int NWR  = 12;  // Bus writes per row at most.

    logic        clk_l;
    logic        rst_n;
    logic        bus_en;
    logic        bus_we;
    logic [1:0]  bus_sel;
    logic [3:0]  bus_addr;
    logic [15:0] bus_wdata;
    logic [3:0]  pwm_out;
    logic        period_start;
    logic        req;
    int          test_id;
    logic [7:0]  cur_cycle;
    int          cur_nper;
    logic        cur_align;
    logic [5:0][3:0][7:0] cur_duty;
    logic [3:0][7:0]      cur_phase;
    int          done_cnt;
    int          err_cnt;

    // Stimulus and expected values, one row per test.
    int          nwr [NROW];
    logic [1:0]  wr_sel [NROW][NWR];
    logic [3:0]  wr_addr [NROW][NWR];
    logic [15:0] wr_data [NROW][NWR];
    logic [7:0]  row_cycle [NROW];
    int          row_nper [NROW];
    logic        row_align [NROW];
    logic [5:0][3:0][7:0] row_duty [NROW];
    logic [3:0][7:0]      row_phase [NROW];

    logic [31:0] lfsr;

    xdcr_drive_top dut_i (
        .clk_l, .rst_n, .bus_en, .bus_we, .bus_sel, .bus_addr, .bus_wdata,
        .pwm_out, .period_start
    );

    xdcr_drive_checker checker_i (
        .clk_l, .rst_n, .pwm_out, .period_start, .req, .test_id,
        .exp_cycle(cur_cycle), .n_per(cur_nper), .align(cur_align),
        .exp_duty(cur_duty), .exp_phase(cur_phase), .done_cnt, .err_cnt
    );

    initial begin
        clk_l = 1'b0;
        forever #5 clk_l = ~clk_l;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Eight LFSR steps, one per bit.
    task automatic draw_byte(output logic [7:0] v);
        v = '0;
        repeat (8) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic add_wr(input int r, input logic [1:0] s, input logic [3:0] a,
                          input logic [15:0] d);
        wr_sel[r][nwr[r]]  = s;
        wr_addr[r][nwr[r]] = a;
        wr_data[r][nwr[r]] = d;
        nwr[r]++;
    endtask

    task automatic set_steady(input int r, input int ch, input int d, input int ph);
        for (int p = 0; p < 6; p++)
            row_duty[r][p][ch] = 8'(d);
        row_phase[r][ch] = 8'(ph);
    endtask

    task automatic build_table();
        logic [7:0] d;
        logic [7:0] ph;
        int         seq [6];
        for (int r = 0; r < NROW; r++) begin
            nwr[r]       = 0;
            row_nper[r]  = 3;
            row_align[r] = 1'b0;
            row_cycle[r] = 8'd20;
        end
        // Random duty and phase, both stages off.
        add_wr(0, SEL_CTL, ADDR_MODE, 16'h0);
        add_wr(0, SEL_CTL, ADDR_CYCLE, 16'd20);
        row_nper[0] = 4;
        for (int i = 0; i < 4; i++) begin
            draw_byte(d);
            draw_byte(ph);
            d  = d % 20;
            ph = ph % 20;
            add_wr(0, SEL_DP, 4'(i), {ph, d});
            set_steady(0, i, d, ph);
        end
        // Cycle write of 1 is clamped to 2.
        add_wr(1, SEL_CTL, ADDR_CYCLE, 16'd1);
        row_cycle[1] = 8'd2;
        for (int i = 0; i < 4; i++) begin
            add_wr(1, SEL_DP, 4'(i), {8'(i % 2), 8'd1});
            set_steady(1, i, 1, i % 2);
            set_steady(2, i, 1, i % 2);
        end
        add_wr(2, SEL_CTL, ADDR_CYCLE, 16'd7);
        row_cycle[2] = 8'd7;
        // Modulator, samples 128 and 255 alternating every period.
        add_wr(3, SEL_CTL, ADDR_CYCLE, 16'd100);
        add_wr(3, SEL_MOD, 4'd0, 16'd128);
        add_wr(3, SEL_MOD, 4'd1, 16'd255);
        add_wr(3, SEL_CTL, ADDR_MOD_LEN, 16'd2);
        add_wr(3, SEL_CTL, ADDR_MOD_DIV, 16'd1);
        row_cycle[3] = 8'd100;
        row_align[3] = 1'b1;
        row_nper[3]  = 6;
        for (int i = 0; i < 3; i++) begin
            d = 8'(100 - 40 * i);
            add_wr(3, SEL_DP, 4'(i), {8'(5 * i), d});
            row_phase[3][i] = 8'(5 * i);
            for (int p = 0; p < 6; p++)
                row_duty[3][p][i] = (p % 2 == 0) ? 8'((d * 128) >> 8) : 8'((d * 255) >> 8);
        end
        add_wr(3, SEL_CTL, ADDR_MODE, 16'h1);
        // Channel 3 still holds duty 1 and phase 1.
        for (int p = 0; p < 6; p++)
            row_duty[3][p][3] = (p % 2 == 0) ? 8'((1 * 128) >> 8) : 8'((1 * 255) >> 8);
        row_phase[3][3] = 8'd1;
        // Silencer setup, then a slew from 2 to 15 in steps of 3.
        add_wr(4, SEL_CTL, ADDR_MODE, 16'h0);
        add_wr(4, SEL_CTL, ADDR_CYCLE, 16'd20);
        add_wr(5, SEL_CTL, ADDR_STEP, 16'd3);
        add_wr(5, SEL_CTL, ADDR_MODE, 16'h2);
        row_align[5] = 1'b1;
        row_nper[5]  = 6;
        seq = '{5, 8, 11, 14, 15, 15};
        for (int i = 0; i < 4; i++) begin
            add_wr(4, SEL_DP, 4'(i), {8'(i), 8'd2});
            set_steady(4, i, 2, i);
            add_wr(5, SEL_DP, 4'(i), {8'(i), 8'd15});
            row_phase[5][i] = 8'(i);
            for (int p = 0; p < 6; p++)
                row_duty[5][p][i] = 8'(seq[p]);
            set_steady(6, i, 15, i);
        end
        // Channel address out of range.
        add_wr(6, SEL_DP, 4'd6, 16'h0909);
    endtask

    task automatic wait_period_start(output bit ok);
        int k;
        k = 0;
        @(posedge clk_l);
        while (!period_start && k < 600) begin
            @(posedge clk_l);
            k++;
        end
        ok = period_start;
    endtask

    task automatic run_row(input int r, output bit ok);
        int start;
        int k;
        wait_period_start(ok);
        if (!ok) begin
            $display("test %0d: no period_start before the writes", r);
            return;
        end
        for (int w = 0; w < nwr[r]; w++) begin
            @(negedge clk_l);
            bus_en    = 1'b1;
            bus_we    = 1'b1;
            bus_sel   = wr_sel[r][w];
            bus_addr  = wr_addr[r][w];
            bus_wdata = wr_data[r][w];
        end
        @(negedge clk_l);
        bus_en    = 1'b0;
        bus_we    = 1'b0;
        test_id   = r;
        cur_cycle = row_cycle[r];
        cur_nper  = row_nper[r];
        cur_align = row_align[r];
        cur_duty  = row_duty[r];
        cur_phase = row_phase[r];
        start     = done_cnt;
        req       = 1'b1;
        @(negedge clk_l);
        req = 1'b0;
        k   = 0;
        while (done_cnt == start && k < 20000) begin
            @(posedge clk_l);
            k++;
        end
        ok = (done_cnt != start);
        if (!ok)
            $display("test %0d: checker did not finish in time", r);
    endtask

    initial begin
        bit ok;
        rst_n     = 1'b0;
        bus_en    = 1'b0;
        bus_we    = 1'b0;
        bus_sel   = '0;
        bus_addr  = '0;
        bus_wdata = '0;
        req       = 1'b0;
        test_id   = 0;
        cur_cycle = '0;
        cur_nper  = 0;
        cur_align = 1'b0;
        cur_duty  = '0;
        cur_phase = '0;
        lfsr      = 32'he3b7;
        build_table();
        repeat (10) @(posedge clk_l);
        @(negedge clk_l);
        rst_n = 1'b1;
        ok    = 1'b1;
        for (int r = 0; r < NROW && ok; r++)
            run_row(r, ok);
        $display("%0d tests run, %0d failures", done_cnt, err_cnt);
        if (ok && err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: xdcr_drive_top.f
logic/xdcr_pkg.sv
logic/cpu_bus_if.sv
logic/ctl_regs.sv
logic/duty_phase_ram.sv
logic/modulator.sv
logic/silencer.sv
logic/pwm_gen.sv
logic/xdcr_drive_top.sv
test/xdcr_drive_checker.sv
test/xdcr_drive_tb.sv
